//--- include/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_XLEN     32
`define ALU_SHAMT_W  5

// Operation codes. Codes 24 to 31 are rejected by the register block.
`define ALU_OP_ADD     5'd0
`define ALU_OP_SUB     5'd1
`define ALU_OP_SLL     5'd2
`define ALU_OP_SRL     5'd3
`define ALU_OP_SRA     5'd4
`define ALU_OP_OR      5'd5
`define ALU_OP_AND     5'd6
`define ALU_OP_XOR     5'd7
`define ALU_OP_SLT     5'd8
`define ALU_OP_SLTU    5'd9
`define ALU_OP_MUL     5'd10
`define ALU_OP_MULH    5'd11
`define ALU_OP_MULHSU  5'd12
`define ALU_OP_MULHU   5'd13
`define ALU_OP_DIV     5'd14
`define ALU_OP_DIVU    5'd15
`define ALU_OP_REM     5'd16
`define ALU_OP_REMU    5'd17
`define ALU_OP_BEQ     5'd18
`define ALU_OP_BNE     5'd19
`define ALU_OP_BLT     5'd20
`define ALU_OP_BGE     5'd21
`define ALU_OP_BLTU    5'd22
`define ALU_OP_BGEU    5'd23

`define ALU_REG_OPA     5'h00
`define ALU_REG_OPB     5'h04
`define ALU_REG_OP      5'h08
`define ALU_REG_RESULT  5'h0C
`define ALU_REG_STATUS  5'h10

`endif

//--- design/alu_pkg.sv
`default_nettype none

`include "alu_config.svh"

package alu_pkg;

	typedef logic [`ALU_XLEN-1:0] word_t;
	typedef logic [2*`ALU_XLEN-1:0] dword_t;
	typedef logic [4:0] op_code_t;
	typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

	// Byte address on the register bus and its write strobes.
	typedef logic [4:0] addr_t;
	typedef logic [`ALU_XLEN/8-1:0] strb_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} div_state_t;

endpackage

`default_nettype wire

//--- design/alu_shifter.sv
`default_nettype none

`include "alu_config.svh"

module alu_shifter (
	input  alu_pkg::word_t    operand,
	input  alu_pkg::shamt_t   shamt,
	input  alu_pkg::op_code_t op,
	output alu_pkg::word_t    result
);

	logic           shift_left;
	logic           fill;
	alu_pkg::word_t reversed;
	alu_pkg::word_t stage [0:`ALU_SHAMT_W];

	assign shift_left = (op == `ALU_OP_SLL);
	assign fill       = (op == `ALU_OP_SRA) & operand[`ALU_XLEN-1];

	// A left shift is a right shift of the bit-reversed word.
	for (genvar b = 0; b < `ALU_XLEN; b++) begin : g_rev_in
		assign reversed[b] = operand[`ALU_XLEN-1-b];
	end

	assign stage[0] = shift_left ? reversed : operand;

	for (genvar i = 0; i < `ALU_SHAMT_W; i++) begin : g_stage
		assign stage[i+1] = shamt[i] ?
			{{(1 << i){fill}}, stage[i][`ALU_XLEN-1:(1 << i)]} : stage[i];
	end

	for (genvar b = 0; b < `ALU_XLEN; b++) begin : g_rev_out
		assign result[b] = shift_left ? stage[`ALU_SHAMT_W][`ALU_XLEN-1-b] :
			stage[`ALU_SHAMT_W][b];
	end

endmodule

`default_nettype wire

//--- design/alu_multiplier.sv
`default_nettype none

`include "alu_config.svh"

module alu_multiplier (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  alu_pkg::op_code_t op,
	input  alu_pkg::word_t    opa,
	input  alu_pkg::word_t    opb,
	output logic              out_valid,
	output alu_pkg::dword_t   product
);

	logic                       a_signed;
	logic                       b_signed;
	logic                       valid_s1;
	logic signed [`ALU_XLEN:0]  a_s1;
	logic signed [`ALU_XLEN:0]  b_s1;
	logic signed [2*`ALU_XLEN+1:0] full;

	// MULHU treats both operands as unsigned, MULHSU only the second.
	assign a_signed = (op != `ALU_OP_MULHU);
	assign b_signed = (op == `ALU_OP_MUL) | (op == `ALU_OP_MULH);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_s1  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid_s1  <= in_valid;
			out_valid <= valid_s1;
		end
	end

	always_ff @(posedge clk) begin
		a_s1 <= {a_signed & opa[`ALU_XLEN-1], opa};
		b_s1 <= {b_signed & opb[`ALU_XLEN-1], opb};
	end

	assign full = a_s1 * b_s1;

	always_ff @(posedge clk) begin
		product <= full[2*`ALU_XLEN-1:0];
	end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> ##2 out_valid);

endmodule

`default_nettype wire

//--- design/alu_divider.sv
`default_nettype none

`include "alu_config.svh"

module alu_divider (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           start,
	input  logic           is_signed,
	input  alu_pkg::word_t dividend,
	input  alu_pkg::word_t divisor,
	output logic           done,
	output alu_pkg::word_t quotient,
	output alu_pkg::word_t remainder
);

	alu_pkg::div_state_t state;
	logic [4:0]          count;

	logic                a_neg;
	alu_pkg::word_t      a_mag;
	alu_pkg::word_t      b_mag;
	alu_pkg::word_t      quo_q;
	alu_pkg::word_t      rem_q;
	alu_pkg::word_t      dvs_q;
	logic                q_neg;
	logic                r_neg;
	logic [`ALU_XLEN:0]  shifted;
	logic [`ALU_XLEN+1:0] diff;

	assign a_neg = is_signed & dividend[`ALU_XLEN-1];
	assign a_mag = a_neg ? -dividend : dividend;
	assign b_mag = (is_signed & divisor[`ALU_XLEN-1]) ? -divisor : divisor;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= alu_pkg::IDLE;
			count <= '0;
		end else begin
			case (state)
				alu_pkg::IDLE: begin
					if (start) begin
						state <= alu_pkg::RUN;
						count <= '0;
					end
				end
				alu_pkg::RUN: begin
					count <= count + 5'd1;
					if (count == 5'd31)
						state <= alu_pkg::DONE;
				end
				default: state <= alu_pkg::IDLE;
			endcase
		end
	end

	// Bring down the next dividend bit and try to subtract the divisor.
	assign shifted = {rem_q, quo_q[`ALU_XLEN-1]};
	assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

	always_ff @(posedge clk) begin
		if (state == alu_pkg::IDLE && start) begin
			quo_q <= a_mag;
			rem_q <= '0;
			dvs_q <= b_mag;
			// A zero divisor keeps the all-ones quotient unsigned.
			q_neg <= is_signed & (dividend[`ALU_XLEN-1] ^ divisor[`ALU_XLEN-1]) &
				(divisor != '0);
			r_neg <= a_neg;
		end else if (state == alu_pkg::RUN) begin
			if (!diff[`ALU_XLEN+1]) begin
				rem_q <= diff[`ALU_XLEN-1:0];
				quo_q <= {quo_q[`ALU_XLEN-2:0], 1'b1};
			end else begin
				rem_q <= shifted[`ALU_XLEN-1:0];
				quo_q <= {quo_q[`ALU_XLEN-2:0], 1'b0};
			end
		end
	end

	assign done      = (state == alu_pkg::DONE);
	assign quotient  = q_neg ? -quo_q : quo_q;
	assign remainder = r_neg ? -rem_q : rem_q;

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> state == alu_pkg::IDLE);

	a_done_after_run: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(state) == alu_pkg::RUN && $past(count) == 5'd31);

endmodule

`default_nettype wire

//--- design/alu_core.sv
`default_nettype none

`include "alu_config.svh"

module alu_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  alu_pkg::op_code_t op,
	input  alu_pkg::word_t    opa,
	input  alu_pkg::word_t    opb,
	output logic              busy,
	output logic              done,
	output alu_pkg::word_t    result,
	output logic              branch_taken
);

	logic               is_mul;
	logic               is_div;
	logic               is_single;
	logic               is_unsigned_cmp;
	logic               sub_like;
	logic [`ALU_XLEN:0] add_ans;
	logic               lt;
	logic               eq;
	logic               cond;
	alu_pkg::word_t     sft_ans;
	alu_pkg::word_t     sc_result;
	logic               mul_valid;
	alu_pkg::dword_t    product;
	logic               div_done;
	alu_pkg::word_t     quotient;
	alu_pkg::word_t     remainder;

	assign is_mul    = (op >= `ALU_OP_MUL) && (op <= `ALU_OP_MULHU);
	assign is_div    = (op >= `ALU_OP_DIV) && (op <= `ALU_OP_REMU);
	assign is_single = !is_mul && !is_div;

	assign is_unsigned_cmp = (op == `ALU_OP_SLTU) | (op == `ALU_OP_BLTU) |
		(op == `ALU_OP_BGEU);
	assign sub_like = (op != `ALU_OP_ADD);

	// One 33-bit adder. Bit 32 is the sign of the exact difference for compares.
	assign add_ans = {~is_unsigned_cmp & opa[`ALU_XLEN-1], opa} +
		({(`ALU_XLEN+1){sub_like}} ^ {~is_unsigned_cmp & opb[`ALU_XLEN-1], opb}) +
		{{`ALU_XLEN{1'b0}}, sub_like};

	assign lt = add_ans[`ALU_XLEN];
	assign eq = (add_ans[`ALU_XLEN-1:0] == '0);

	always_comb begin
		case (op)
			`ALU_OP_BEQ:                cond = eq;
			`ALU_OP_BNE:                cond = ~eq;
			`ALU_OP_BLT, `ALU_OP_BLTU:  cond = lt;
			`ALU_OP_BGE, `ALU_OP_BGEU:  cond = ~lt;
			default:                    cond = 1'b0;
		endcase
	end

	always_comb begin
		case (op)
			`ALU_OP_ADD, `ALU_OP_SUB:                sc_result = add_ans[`ALU_XLEN-1:0];
			`ALU_OP_SLL, `ALU_OP_SRL, `ALU_OP_SRA:  sc_result = sft_ans;
			`ALU_OP_OR:                              sc_result = opa | opb;
			`ALU_OP_AND:                             sc_result = opa & opb;
			`ALU_OP_XOR:                             sc_result = opa ^ opb;
			`ALU_OP_SLT, `ALU_OP_SLTU:               sc_result = {{(`ALU_XLEN-1){1'b0}}, lt};
			default:                                 sc_result = {{(`ALU_XLEN-1){1'b0}}, cond};
		endcase
	end

	alu_shifter u_shifter (
		.operand (opa),
		.shamt   (opb[`ALU_SHAMT_W-1:0]),
		.op      (op),
		.result  (sft_ans)
	);

	alu_multiplier u_multiplier (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (start & is_mul),
		.op        (op),
		.opa       (opa),
		.opb       (opb),
		.out_valid (mul_valid),
		.product   (product)
	);

	alu_divider u_divider (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start & is_div),
		.is_signed ((op == `ALU_OP_DIV) | (op == `ALU_OP_REM)),
		.dividend  (opa),
		.divisor   (opb),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= (start & is_single) | mul_valid | div_done;
			if (start)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	// The operation code stays stable until done, so it steers the selection.
	always_ff @(posedge clk) begin
		if (start && is_single) begin
			result       <= sc_result;
			branch_taken <= cond;
		end else if (mul_valid) begin
			result       <= (op == `ALU_OP_MUL) ? product[`ALU_XLEN-1:0] :
				product[2*`ALU_XLEN-1:`ALU_XLEN];
			branch_taken <= 1'b0;
		end else if (div_done) begin
			result       <= ((op == `ALU_OP_DIV) | (op == `ALU_OP_DIVU)) ? quotient : remainder;
			branch_taken <= 1'b0;
		end
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

`default_nettype wire

//--- design/alu_regs.sv
`default_nettype none

`include "alu_config.svh"

module alu_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              awvalid,
	output logic              awready,
	input  alu_pkg::addr_t    awaddr,
	input  logic              wvalid,
	output logic              wready,
	input  alu_pkg::word_t    wdata,
	input  alu_pkg::strb_t    wstrb,
	output logic              bvalid,
	input  logic              bready,
	output logic [1:0]        bresp,
	input  logic              arvalid,
	output logic              arready,
	input  alu_pkg::addr_t    araddr,
	output logic              rvalid,
	input  logic              rready,
	output alu_pkg::word_t    rdata,
	output logic [1:0]        rresp,
	output logic              start,
	output alu_pkg::op_code_t op,
	output alu_pkg::word_t    opa,
	output alu_pkg::word_t    opb,
	input  logic              busy,
	input  logic              done,
	input  alu_pkg::word_t    result,
	input  logic              branch_taken
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic           wr_ready;
	logic           wr_hs;
	logic           rd_hs;
	logic           busy_any;
	logic           op_legal;
	logic           done_q;
	logic           branch_q;
	alu_pkg::word_t result_q;
	alu_pkg::word_t rd_word;
	logic           rd_err;

	function automatic alu_pkg::word_t apply_strb(input alu_pkg::word_t cur,
		input alu_pkg::word_t data, input alu_pkg::strb_t strb);
		alu_pkg::word_t res;
		res = cur;
		for (int i = 0; i < `ALU_XLEN/8; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	assign awready  = wr_ready;
	assign wready   = wr_ready;
	assign wr_hs    = wr_ready & awvalid & wvalid;
	assign rd_hs    = arready & arvalid;
	// The start cycle counts as busy, since the core only raises busy a cycle later.
	assign busy_any = busy | start;
	assign op_legal = (wdata[4:0] <= `ALU_OP_BGEU);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ready <= 1'b0;
			bvalid   <= 1'b0;
			bresp    <= RESP_OKAY;
			start    <= 1'b0;
			op       <= '0;
			opa      <= '0;
			opb      <= '0;
			done_q   <= 1'b0;
			branch_q <= 1'b0;
			result_q <= '0;
		end else begin
			start    <= 1'b0;
			wr_ready <= awvalid & wvalid & ~bvalid & ~wr_ready;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (done) begin
				result_q <= result;
				branch_q <= branch_taken;
				done_q   <= 1'b1;
			end
			if (wr_hs) begin
				bvalid <= 1'b1;
				bresp  <= RESP_OKAY;
				case (awaddr)
					`ALU_REG_OPA: opa <= apply_strb(opa, wdata, wstrb);
					`ALU_REG_OPB: opb <= apply_strb(opb, wdata, wstrb);
					`ALU_REG_OP: begin
						if (wstrb[0]) begin
							if (!busy_any && op_legal) begin
								op     <= wdata[4:0];
								done_q <= 1'b0;
								start  <= 1'b1;
							end else begin
								bresp <= RESP_SLVERR;
							end
						end
					end
					default: bresp <= RESP_SLVERR;
				endcase
			end
		end
	end

	always_comb begin
		rd_err = 1'b0;
		case (araddr)
			`ALU_REG_OPA:    rd_word = opa;
			`ALU_REG_OPB:    rd_word = opb;
			`ALU_REG_OP:     rd_word = {{(`ALU_XLEN-5){1'b0}}, op};
			`ALU_REG_RESULT: rd_word = result_q;
			`ALU_REG_STATUS: rd_word = {{(`ALU_XLEN-3){1'b0}}, branch_q, done_q, busy_any};
			default: begin
				rd_word = '0;
				rd_err  = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= RESP_OKAY;
		end else begin
			arready <= arvalid & ~rvalid & ~arready;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_hs) begin
				rvalid <= 1'b1;
				rdata  <= rd_word;
				rresp  <= rd_err ? RESP_SLVERR : RESP_OKAY;
			end
		end
	end

	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

`default_nettype wire

//--- design/alu_top.sv
`default_nettype none

module alu_top (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           awvalid,
	output logic           awready,
	input  alu_pkg::addr_t awaddr,
	input  logic           wvalid,
	output logic           wready,
	input  alu_pkg::word_t wdata,
	input  alu_pkg::strb_t wstrb,
	output logic           bvalid,
	input  logic           bready,
	output logic [1:0]     bresp,
	input  logic           arvalid,
	output logic           arready,
	input  alu_pkg::addr_t araddr,
	output logic           rvalid,
	input  logic           rready,
	output alu_pkg::word_t rdata,
	output logic [1:0]     rresp
);

	logic              start;
	logic              busy;
	logic              done;
	logic              branch_taken;
	alu_pkg::op_code_t op;
	alu_pkg::word_t    opa;
	alu_pkg::word_t    opb;
	alu_pkg::word_t    result;

	alu_regs u_regs (
		.clk          (clk),
		.rst_n        (rst_n),
		.awvalid      (awvalid),
		.awready      (awready),
		.awaddr       (awaddr),
		.wvalid       (wvalid),
		.wready       (wready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.bvalid       (bvalid),
		.bready       (bready),
		.bresp        (bresp),
		.arvalid      (arvalid),
		.arready      (arready),
		.araddr       (araddr),
		.rvalid       (rvalid),
		.rready       (rready),
		.rdata        (rdata),
		.rresp        (rresp),
		.start        (start),
		.op           (op),
		.opa          (opa),
		.opb          (opb),
		.busy         (busy),
		.done         (done),
		.result       (result),
		.branch_taken (branch_taken)
	);

	alu_core u_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.op           (op),
		.opa          (opa),
		.opb          (opb),
		.busy         (busy),
		.done         (done),
		.result       (result),
		.branch_taken (branch_taken)
	);

endmodule

`default_nettype wire

//--- test/alu_tb_clock.sv
`default_nettype none

module alu_tb_clock (
	output logic clk
);

	// Period of 4 time units.
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

endmodule

`default_nettype wire

//--- test/alu_tb.sv
`default_nettype none

`include "alu_config.svh"

module alu_tb;

	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 8;
	localparam int NUM_TESTS       = 10 * 20 + 8 * 20 + 6 * 4 + 15;
	localparam int CYCLES_PER_TEST = 60;
	localparam logic [1:0] OKAY    = 2'b00;
	localparam logic [1:0] SLVERR  = 2'b10;

	logic              clk;
	logic              rst_n;
	logic              awvalid;
	logic              awready;
	alu_pkg::addr_t    awaddr;
	logic              wvalid;
	logic              wready;
	alu_pkg::word_t    wdata;
	alu_pkg::strb_t    wstrb;
	logic              bvalid;
	logic              bready;
	logic [1:0]        bresp;
	logic              arvalid;
	logic              arready;
	alu_pkg::addr_t    araddr;
	logic              rvalid;
	logic              rready;
	alu_pkg::word_t    rdata;
	logic [1:0]        rresp;

	alu_pkg::word_t    edge_val [4];
	alu_pkg::op_code_t cur_op;
	alu_pkg::word_t    got_result;
	alu_pkg::word_t    exp_result;
	logic              got_branch;
	logic              exp_branch;
	event              compare_ev;

	alu_tb_clock u_clock (
		.clk (clk)
	);

	alu_top UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.bvalid  (bvalid),
		.bready  (bready),
		.bresp   (bresp),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rresp   (rresp)
	);

	task automatic stop_with_failure();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_word(input string name, input alu_pkg::word_t got,
		input alu_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] got,
		input logic [1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// Expected result from the RISC-V rules, including the M-extension corner cases.
	function automatic alu_pkg::word_t alu_ref(input alu_pkg::op_code_t op,
		input alu_pkg::word_t a, input alu_pkg::word_t b, output logic taken);
		logic signed [`ALU_XLEN-1:0] sa;
		logic signed [`ALU_XLEN-1:0] sb;
		alu_pkg::dword_t             prod;
		alu_pkg::word_t              res;
		logic                        ovf;
		sa    = a;
		sb    = b;
		ovf   = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
		taken = 1'b0;
		res   = '0;
		prod  = '0;
		case (op)
			`ALU_OP_ADD:    res = a + b;
			`ALU_OP_SUB:    res = a - b;
			`ALU_OP_SLL:    res = a << b[4:0];
			`ALU_OP_SRL:    res = a >> b[4:0];
			`ALU_OP_SRA:    res = sa >>> b[4:0];
			`ALU_OP_OR:     res = a | b;
			`ALU_OP_AND:    res = a & b;
			`ALU_OP_XOR:    res = a ^ b;
			`ALU_OP_SLT:    res = {{(`ALU_XLEN-1){1'b0}}, sa < sb};
			`ALU_OP_SLTU:   res = {{(`ALU_XLEN-1){1'b0}}, a < b};
			`ALU_OP_MUL:    res = a * b;
			`ALU_OP_MULH:   prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			`ALU_OP_MULHSU: prod = {{32{a[31]}}, a} * {32'b0, b};
			`ALU_OP_MULHU:  prod = {32'b0, a} * {32'b0, b};
			`ALU_OP_DIV, `ALU_OP_REM: begin
				if (b == '0)
					res = (op == `ALU_OP_DIV) ? '1 : a;
				else if (ovf)
					res = (op == `ALU_OP_DIV) ? a : '0;
				else if (op == `ALU_OP_DIV)
					res = sa / sb;
				else
					res = sa % sb;
			end
			`ALU_OP_DIVU:   res = (b == '0) ? '1 : a / b;
			`ALU_OP_REMU:   res = (b == '0) ? a : a % b;
			`ALU_OP_BEQ:    taken = (a == b);
			`ALU_OP_BNE:    taken = (a != b);
			`ALU_OP_BLT:    taken = (sa < sb);
			`ALU_OP_BGE:    taken = (sa >= sb);
			`ALU_OP_BLTU:   taken = (a < b);
			`ALU_OP_BGEU:   taken = (a >= b);
			default:        res = '0;
		endcase
		if (op >= `ALU_OP_MULH && op <= `ALU_OP_MULHU)
			res = prod[63:32];
		if (op >= `ALU_OP_BEQ)
			res = {{(`ALU_XLEN-1){1'b0}}, taken};
		return res;
	endfunction

	// Mostly no stall on the response channels, now and then a short one.
	function automatic int rand_hold();
		if ($urandom % 4 == 0)
			return $urandom % 5;
		return 0;
	endfunction

	task automatic axi_write(input alu_pkg::addr_t addr, input alu_pkg::word_t data,
		input alu_pkg::strb_t strb, input int hold, output logic [1:0] resp);
		logic seen;
		seen = 1'b0;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		do begin
			@(posedge clk);
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat (hold) begin
			@(posedge clk);
			if (seen && !bvalid) begin
				$display("The write response was withdrawn before bready was raised.");
				stop_with_failure();
			end
			seen = seen | bvalid;
		end
		bready <= 1'b1;
		do begin
			@(posedge clk);
		end while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input alu_pkg::addr_t addr, input int hold,
		output alu_pkg::word_t data, output logic [1:0] resp);
		logic           seen;
		alu_pkg::word_t first;
		seen  = 1'b0;
		first = '0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		do begin
			@(posedge clk);
		end while (!arready);
		arvalid <= 1'b0;
		repeat (hold) begin
			@(posedge clk);
			if (seen && !rvalid) begin
				$display("The read data was withdrawn before rready was raised.");
				stop_with_failure();
			end
			if (seen)
				check_word("rdata while rready is low", rdata, first);
			if (rvalid && !seen) begin
				seen  = 1'b1;
				first = rdata;
			end
		end
		rready <= 1'b1;
		do begin
			@(posedge clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
		if (seen)
			check_word("rdata at the handshake", data, first);
	endtask

	task automatic write_ok(input alu_pkg::addr_t addr, input alu_pkg::word_t data);
		logic [1:0] resp;
		axi_write(addr, data, 4'hF, rand_hold(), resp);
		check_resp($sformatf("bresp of write to 0x%02h", addr), resp, OKAY);
	endtask

	task automatic read_ok(input alu_pkg::addr_t addr, output alu_pkg::word_t data);
		logic [1:0] resp;
		axi_read(addr, rand_hold(), data, resp);
		check_resp($sformatf("rresp of read from 0x%02h", addr), resp, OKAY);
	endtask

	// Poll STATUS until the sticky done bit is set.
	task automatic wait_done();
		alu_pkg::word_t status;
		status = '0;
		while (!status[1])
			read_ok(`ALU_REG_STATUS, status);
	endtask

	task automatic run_op(input alu_pkg::op_code_t op, input alu_pkg::word_t a,
		input alu_pkg::word_t b);
		alu_pkg::word_t status;
		write_ok(`ALU_REG_OPA, a);
		write_ok(`ALU_REG_OPB, b);
		write_ok(`ALU_REG_OP, {27'b0, op});
		wait_done();
		read_ok(`ALU_REG_RESULT, got_result);
		read_ok(`ALU_REG_STATUS, status);
		cur_op     = op;
		got_branch = status[2];
		exp_result = alu_ref(op, a, b, exp_branch);
		->compare_ev;
	endtask

	task automatic sweep_op(input alu_pkg::op_code_t op);
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++)
				run_op(op, edge_val[i], edge_val[j]);
		end
		for (int k = 0; k < 4; k++)
			run_op(op, $urandom, $urandom);
	endtask

	initial begin : compare_results
		forever begin
			@(compare_ev);
			check_word($sformatf("RESULT of op %0d", cur_op), got_result, exp_result);
			check_flag($sformatf("STATUS branch bit of op %0d", cur_op), got_branch,
				exp_branch);
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST));
		$display("The run did not finish in the time allowed for %0d tests.", NUM_TESTS);
		stop_with_failure();
	end

	initial begin : stimulus
		alu_pkg::word_t data;
		alu_pkg::word_t expect_word;
		logic           flag;
		logic [1:0]     resp;
		void'($urandom(42586));
		rst_n       = 1'b0;
		awvalid     = 1'b0;
		awaddr      = '0;
		wvalid      = 1'b0;
		wdata       = '0;
		wstrb       = '0;
		bready      = 1'b0;
		arvalid     = 1'b0;
		araddr      = '0;
		rready      = 1'b0;
		edge_val[0] = 32'h0000_0000;
		edge_val[1] = 32'h0000_0001;
		edge_val[2] = 32'hFFFF_FFFF;
		edge_val[3] = 32'h8000_0000;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		for (int r = 0; r < 5; r++) begin
			read_ok(alu_pkg::addr_t'(4 * r), data);
			check_word($sformatf("register 0x%02h after reset", 4 * r), data, '0);
		end

		for (int code = `ALU_OP_ADD; code <= `ALU_OP_SLTU; code++)
			sweep_op(alu_pkg::op_code_t'(code));
		for (int code = `ALU_OP_MUL; code <= `ALU_OP_REMU; code++)
			sweep_op(alu_pkg::op_code_t'(code));

		// Equal, signed-less and unsigned-less pairs.
		for (int code = `ALU_OP_BEQ; code <= `ALU_OP_BGEU; code++) begin
			data = $urandom;
			run_op(alu_pkg::op_code_t'(code), data, data);
			run_op(alu_pkg::op_code_t'(code), 32'hFFFF_FFFB, 32'd3);
			run_op(alu_pkg::op_code_t'(code), 32'd3, 32'hFFFF_FFFB);
			run_op(alu_pkg::op_code_t'(code), 32'd2, 32'd7);
		end

		// A second OP write lands while the divide is still running.
		write_ok(`ALU_REG_OPA, 32'd100);
		write_ok(`ALU_REG_OPB, 32'd7);
		write_ok(`ALU_REG_OP, {27'b0, `ALU_OP_DIV});
		axi_write(`ALU_REG_OP, {27'b0, `ALU_OP_ADD}, 4'h1, 0, resp);
		check_resp("bresp of OP write while busy", resp, SLVERR);
		wait_done();
		expect_word = alu_ref(`ALU_OP_DIV, 32'd100, 32'd7, flag);
		read_ok(`ALU_REG_RESULT, data);
		check_word("RESULT after rejected OP write", data, expect_word);

		axi_write(`ALU_REG_OP, 32'd24, 4'h1, 0, resp);
		check_resp("bresp of illegal op code", resp, SLVERR);
		read_ok(`ALU_REG_STATUS, data);
		check_flag("STATUS busy bit after illegal code", data[0], 1'b0);
		check_flag("STATUS done bit after illegal code", data[1], 1'b1);
		read_ok(`ALU_REG_OP, data);
		check_word("OP after illegal code", data, {27'b0, `ALU_OP_DIV});

		axi_write(`ALU_REG_RESULT, 32'hDEAD_BEEF, 4'hF, 0, resp);
		check_resp("bresp of write to RESULT", resp, SLVERR);
		read_ok(`ALU_REG_RESULT, data);
		check_word("RESULT after write attempt", data, expect_word);

		write_ok(`ALU_REG_OPA, 32'h1122_3344);
		axi_write(`ALU_REG_OPA, 32'hAABB_CCDD, 4'b0101, 0, resp);
		check_resp("bresp of partial OPA write", resp, OKAY);
		read_ok(`ALU_REG_OPA, data);
		check_word("OPA after partial write", data, 32'h11BB_33DD);

		for (int n = 0; n < 6; n++) begin
			expect_word = $urandom;
			axi_write(`ALU_REG_OPB, expect_word, 4'hF, 3 + $urandom % 8, resp);
			check_resp("bresp under back-pressure", resp, OKAY);
			axi_read(`ALU_REG_OPB, 3 + $urandom % 8, data, resp);
			check_resp("rresp under back-pressure", resp, OKAY);
			check_word("OPB readback under back-pressure", data, expect_word);
		end

		repeat (4) @(posedge clk);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
design/alu_pkg.sv
design/alu_shifter.sv
design/alu_multiplier.sv
design/alu_divider.sv
design/alu_core.sv
design/alu_regs.sv
design/alu_top.sv
test/alu_tb_clock.sv
test/alu_tb.sv

//--- Makefile
TOP = alu_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
